//--- files.f
design/memory_game_pkg.sv
design/start_conditioner.sv
design/game_ctrl.sv
design/vga_timing.sv
design/tile_addr_gen.sv
design/tile_pixel.sv
design/memory_game_top.sv
testbench/memory_game_assert.sv
testbench/memory_game_tb.sv

//--- run.sh
#!/bin/sh
cd "$(dirname "$0")" &&
verilator --binary --timing --assert --timescale 1ns/1ps \
    -f files.f --top-module memory_game_tb -Mdir obj_dir -o memory_game_sim &&
./obj_dir/memory_game_sim || exit 1

//--- testbench/memory_game_tb.sv
`timescale 1ns/1ps
`default_nettype none

module memory_game_tb;

    localparam int H_ACTIVE       = 16;
    localparam int H_FRONT        = 2;
    localparam int H_SYNC         = 3;
    localparam int H_BACK         = 3;
    localparam int V_ACTIVE       = 16;
    localparam int V_FRONT        = 1;
    localparam int V_SYNC         = 2;
    localparam int V_BACK         = 1;
    localparam int DEBOUNCE_LEN   = 7;
    localparam int H_TOTAL        = H_ACTIVE + H_FRONT + H_SYNC + H_BACK;
    localparam int FRAME_CYCLES   = H_TOTAL * (V_ACTIVE + V_FRONT + V_SYNC + V_BACK);
    localparam int TILE_W         = H_ACTIVE / 4;
    localparam int TILE_H         = V_ACTIVE / 4;
    localparam int NUM_TESTS      = 5;
    localparam int TIMEOUT_CYCLES = 8 * FRAME_CYCLES + 2000 * NUM_TESTS;

    logic                         clk;
    logic                         rst;
    logic                         start_i;
    logic                         hint_i;
    logic                         pick_valid_i;
    memory_game_pkg::pick_t       pick_i;
    logic                         credit_o;
    memory_game_pkg::vga_out_t    vga_o;
    memory_game_pkg::game_state_e state_o;
    memory_game_pkg::card_mask_t  visible_o;
    logic                         pass_o;

    // Reference model of the game rules
    memory_game_pkg::game_state_e m_state;
    memory_game_pkg::card_mask_t  m_shown;
    memory_game_pkg::card_mask_t  m_good;
    memory_game_pkg::card_mask_t  m_flip;
    logic                         m_armed;
    logic                         m_hint;
    int                           m_count;
    int                           credits = 0;
    int                           cycle_count = 0;
    logic [7:0]                   lfsr_q = 8'd48;
    string                        cur_test;

    memory_game_top #(
        .DEBOUNCE_LEN(DEBOUNCE_LEN),
        .H_ACTIVE(H_ACTIVE), .H_FRONT(H_FRONT), .H_SYNC(H_SYNC), .H_BACK(H_BACK),
        .V_ACTIVE(V_ACTIVE), .V_FRONT(V_FRONT), .V_SYNC(V_SYNC), .V_BACK(V_BACK)
    ) UUT (
        .clk         (clk),
        .rst         (rst),
        .start_i     (start_i),
        .hint_i      (hint_i),
        .pick_valid_i(pick_valid_i),
        .pick_i      (pick_i),
        .credit_o    (credit_o),
        .vga_o       (vga_o),
        .state_o     (state_o),
        .visible_o   (visible_o),
        .pass_o      (pass_o)
    );

    always #10 clk = ~clk;

    always @(posedge clk) begin
        cycle_count <= cycle_count + 1;
        if (cycle_count > TIMEOUT_CYCLES) begin
            $display("Timeout: run did not finish within %0d cycles", TIMEOUT_CYCLES);
            stop_run();
        end
    end

    task automatic stop_run();
        $display("Test failed");
        $fatal(1, "stopped at the first error");
    endtask

    task automatic step();
        @(negedge clk);
    endtask

    task automatic check_state(string what, memory_game_pkg::game_state_e exp,
                               memory_game_pkg::game_state_e act);
        if (act !== exp) begin
            $display("FAILED %s: %s expected %s actual %s", cur_test, what,
                     exp.name(), act.name());
            stop_run();
        end
    endtask

    task automatic check_mask(string what, memory_game_pkg::card_mask_t exp,
                              memory_game_pkg::card_mask_t act);
        if (act !== exp) begin
            $display("FAILED %s: %s expected %h actual %h", cur_test, what, exp, act);
            stop_run();
        end
    endtask

    task automatic check_rgb(string what, memory_game_pkg::rgb_t exp,
                             memory_game_pkg::rgb_t act);
        if (act !== exp) begin
            $display("FAILED %s: %s expected %h actual %h", cur_test, what, exp, act);
            stop_run();
        end
    endtask

    task automatic check_bit(string what, logic exp, logic act);
        if (act !== exp) begin
            $display("FAILED %s: %s expected %b actual %b", cur_test, what, exp, act);
            stop_run();
        end
    endtask

    // Galois form, taps x^8 + x^6 + x^5 + x^4 + 1
    function automatic logic [7:0] lfsr_next(logic [7:0] s);
        return s[0] ? ((s >> 1) ^ 8'hB8) : (s >> 1);
    endfunction

    task automatic take_bits(input int n, output int value);
        value = 0;
        for (int i = 0; i < n; i++) begin
            value = (value << 1) | int'(lfsr_q[0]);
            lfsr_q = lfsr_next(lfsr_q);
        end
    endtask

    function automatic memory_game_pkg::card_mask_t show_flips();
        memory_game_pkg::card_mask_t m;
        m = '0;
        m[0] = 1'b1;
        m[1] = 1'b1;
        m[13] = 1'b1;
        m[14] = 1'b1;
        return m;
    endfunction

    function automatic memory_game_pkg::card_mask_t expect_visible();
        if (m_state == memory_game_pkg::GAME && m_hint) begin
            return '1;
        end
        return m_shown | m_good;
    endfunction

    function automatic memory_game_pkg::rgb_t expect_pixel(int h, int v);
        int                          card;
        int                          row;
        logic [7:0]                  pal;
        memory_game_pkg::card_mask_t vis;
        memory_game_pkg::rgb_t       px;
        card = (v / TILE_H) * 4 + h / TILE_W;
        row = v % TILE_H;
        if (m_flip[4'(card)]) begin
            row = TILE_H - 1 - row;
        end
        pal = memory_game_pkg::PICTURE_PALETTE[3'(card % memory_game_pkg::NUM_PICTURES)];
        px.red = pal[7:4];
        px.green = pal[3:0];
        px.blue = 4'(row);
        vis = expect_visible();
        return vis[4'(card)] ? px : '0;
    endfunction

    task automatic model_pick(memory_game_pkg::pick_t p);
        if (m_state != memory_game_pkg::GAME || m_hint) begin
            return;
        end
        case (p.op)
            memory_game_pkg::PICK_PAIR: begin
                if (m_armed && p.first != p.second) begin
                    m_shown[p.first] = 1'b1;
                    m_shown[p.second] = 1'b1;
                    m_armed = 1'b0;
                    if (p.first % memory_game_pkg::NUM_PICTURES
                            == p.second % memory_game_pkg::NUM_PICTURES
                        && m_flip[p.first] == m_flip[p.second]
                        && !m_good[p.first] && !m_good[p.second]) begin
                        m_good[p.first] = 1'b1;
                        m_good[p.second] = 1'b1;
                        m_count++;
                        if (m_count == memory_game_pkg::WIN_MATCHES) begin
                            m_state = memory_game_pkg::FINISH;
                        end
                    end
                end
            end
            memory_game_pkg::PICK_ROTATE: begin
                if (m_armed) begin
                    m_shown[p.first] = 1'b1;
                    m_flip[p.first] = ~m_flip[p.first];
                    m_armed = 1'b0;
                end
            end
            default: begin
                if (!m_armed) begin
                    m_shown = '0;
                    m_armed = 1'b1;
                end
            end
        endcase
    endtask

    task automatic wait_credit();
        int waited = 0;
        while (!credit_o) begin
            step();
            waited++;
            if (waited > 8) begin
                $display("No credit came back from the DUT in %s", cur_test);
                stop_run();
            end
        end
        credits++;
    endtask

    task automatic wait_state(memory_game_pkg::game_state_e target);
        int waited = 0;
        while (state_o != target) begin
            step();
            waited++;
            if (waited > 64) begin
                $display("State %s never reached in %s", target.name(), cur_test);
                stop_run();
            end
        end
    endtask

    task automatic send_pick(memory_game_pkg::pick_op_e op, int first, int second);
        memory_game_pkg::pick_t p;
        p.op = op;
        p.first = 4'(first);
        p.second = 4'(second);
        if (credits == 0) begin
            $display("Pick attempted without a credit in %s", cur_test);
            stop_run();
        end
        pick_i = p;
        pick_valid_i = 1'b1;
        credits--;
        step();
        pick_valid_i = 1'b0;
        wait_credit();
        model_pick(p);
        check_mask("visible after pick", expect_visible(), visible_o);
        step();
        check_bit("credit pulse length", 1'b0, credit_o);
    endtask

    task automatic press_start();
        start_i = 1'b1;
        repeat (DEBOUNCE_LEN + 4) step();
        case (m_state)
            memory_game_pkg::INIT: begin
                m_state = memory_game_pkg::SHOW;
                m_shown = '1;
                m_flip = show_flips();
            end
            memory_game_pkg::SHOW: begin
                m_state = memory_game_pkg::GAME;
                m_shown = '0;
            end
            memory_game_pkg::FINISH: begin
                m_state = memory_game_pkg::INIT;
                m_shown = '0;
                m_good = '0;
                m_flip = '0;
                m_count = 0;
            end
            default: ;
        endcase
        m_armed = 1'b1;
        check_state("state after start press", m_state, state_o);
        start_i = 1'b0;
        repeat (2) step();
        check_mask("visible after start press", expect_visible(), visible_o);
    endtask

    task automatic wait_sync(logic use_vsync, logic level);
        int waited = 0;
        while ((use_vsync ? vga_o.vsync : vga_o.hsync) !== level) begin
            step();
            waited++;
            if (waited > FRAME_CYCLES) begin
                $display("Sync never toggled while capturing a frame in %s", cur_test);
                stop_run();
            end
        end
    endtask

    task automatic check_frame();
        // End of vsync, then end of hsync; pixel 0 of line 0 is H_BACK later
        wait_sync(1'b1, 1'b0);
        wait_sync(1'b1, 1'b1);
        wait_sync(1'b0, 1'b0);
        wait_sync(1'b0, 1'b1);
        repeat (H_BACK) step();
        for (int v = 0; v < V_ACTIVE; v++) begin
            for (int h = 0; h < H_TOTAL; h++) begin
                if (h < H_ACTIVE) begin
                    check_rgb($sformatf("pixel (%0d,%0d)", h, v), expect_pixel(h, v),
                              vga_o.rgb);
                end else begin
                    check_rgb($sformatf("blanked pixel (%0d,%0d)", h, v), '0, vga_o.rgb);
                end
                step();
            end
        end
    endtask

    task automatic reset_and_start();
        cur_test = "reset_and_start";
        check_state("state after reset", memory_game_pkg::INIT, state_o);
        check_mask("visible after reset", '0, visible_o);
        check_bit("pass after reset", 1'b0, pass_o);
        check_bit("credit after reset", 1'b0, credit_o);
        check_bit("hsync after reset", 1'b1, vga_o.hsync);
        check_bit("vsync after reset", 1'b1, vga_o.vsync);
        wait_credit();
        repeat (6) begin
            step();
            check_bit("single boot credit", 1'b0, credit_o);
        end
        press_start();
    endtask

    task automatic show_frame();
        cur_test = "show_frame";
        check_frame();
        // Second press leaves SHOW for GAME
        press_start();
    endtask

    task automatic mismatch_rotate_clear();
        cur_test = "mismatch_rotate_clear";
        send_pick(memory_game_pkg::PICK_PAIR, 0, 8);
        send_pick(memory_game_pkg::PICK_CLEAR, 0, 0);
        send_pick(memory_game_pkg::PICK_ROTATE, 8, 0);
        send_pick(memory_game_pkg::PICK_CLEAR, 0, 0);
        send_pick(memory_game_pkg::PICK_PAIR, 0, 8);
        send_pick(memory_game_pkg::PICK_CLEAR, 0, 0);
        // Solved cards stay up after a clear
        check_mask("pair 0/8 solved", 16'h0101, visible_o);
        // Rematching a solved pair opens it again but scores nothing
        send_pick(memory_game_pkg::PICK_PAIR, 0, 8);
    endtask

    task automatic ignored_events();
        cur_test = "ignored_events";
        send_pick(memory_game_pkg::PICK_PAIR, 1, 9);
        hint_i = 1'b1;
        m_hint = 1'b1;
        step();
        check_mask("visible with hint", '1, visible_o);
        send_pick(memory_game_pkg::PICK_CLEAR, 0, 0);
        send_pick(memory_game_pkg::PICK_ROTATE, 2, 0);
        check_frame();
        hint_i = 1'b0;
        m_hint = 1'b0;
        step();
        check_mask("visible after hint", expect_visible(), visible_o);
        send_pick(memory_game_pkg::PICK_CLEAR, 0, 0);
    endtask

    task automatic full_game();
        int pictures[$];
        int choice;
        int pic;
        cur_test = "full_game";
        for (int p = 1; p < memory_game_pkg::NUM_PICTURES; p++) begin
            pictures.push_back(p);
        end
        while (pictures.size() > 0) begin
            take_bits(3, choice);
            choice = choice % pictures.size();
            pic = pictures[choice];
            pictures.delete(choice);
            if (!m_armed) begin
                send_pick(memory_game_pkg::PICK_CLEAR, 0, 0);
            end
            if (m_flip[4'(pic)] != m_flip[4'(pic + 8)]) begin
                send_pick(memory_game_pkg::PICK_ROTATE, pic + 8, 0);
                send_pick(memory_game_pkg::PICK_CLEAR, 0, 0);
            end
            send_pick(memory_game_pkg::PICK_PAIR, pic, pic + 8);
        end
        wait_state(memory_game_pkg::FINISH);
        check_state("state after last pair", m_state, state_o);
        m_shown = '1;
        check_bit("pass in FINISH", 1'b1, pass_o);
        check_mask("visible in FINISH", '1, visible_o);
        press_start();
        check_bit("pass back in INIT", 1'b0, pass_o);
    endtask

    initial begin
        clk = 1'b0;
        rst = 1'b1;
        start_i = 1'b0;
        hint_i = 1'b0;
        pick_valid_i = 1'b0;
        pick_i = '0;
        m_state = memory_game_pkg::INIT;
        m_shown = '0;
        m_good = '0;
        m_flip = '0;
        m_armed = 1'b1;
        m_hint = 1'b0;
        m_count = 0;
        cur_test = "reset";
        repeat (4) step();
        rst = 1'b0;
        reset_and_start();
        show_frame();
        mismatch_rotate_clear();
        ignored_events();
        full_game();
        $display("Test completed successfully");
        $finish;
    end

endmodule

`default_nettype wire

//--- testbench/memory_game_assert.sv
`timescale 1ns/1ps
`default_nettype none

module memory_game_assert (
    input logic                         clk,
    input logic                         rst,
    input logic                         pick_valid_i,
    input logic                         credit_o,
    input logic                         pass_o,
    input memory_game_pkg::game_state_e state_o,
    input memory_game_pkg::card_mask_t  visible_o,
    input memory_game_pkg::vga_out_t    vga_o
);

    logic [1:0] credits_q;

    // Credits held by the sender
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            credits_q <= '0;
        end else begin
            credits_q <= credits_q + 2'(credit_o) - 2'(pick_valid_i);
        end
    end

    // A credit pulse in the same cycle counts as available
    pick_needs_credit: assert property (@(posedge clk) disable iff (rst)
        pick_valid_i |-> (credits_q != 2'd0 || credit_o))
        else $error("pick_valid_i raised with no credit");

    // A won game has every card solved
    pass_only_in_finish: assert property (@(posedge clk) disable iff (rst)
        pass_o |-> (state_o == memory_game_pkg::FINISH && visible_o == '1))
        else $error("pass_o high outside FINISH or with cards hidden");

    black_during_sync: assert property (@(posedge clk) disable iff (rst)
        (!vga_o.hsync || !vga_o.vsync) |-> vga_o.rgb == '0)
        else $error("rgb not black while a sync is low");

    credit_single_cycle: assert property (@(posedge clk) disable iff (rst)
        credit_o |=> !credit_o)
        else $error("credit_o high on two consecutive cycles");

endmodule

bind memory_game_top memory_game_assert u_assert (
    .clk         (clk),
    .rst         (rst),
    .pick_valid_i(pick_valid_i),
    .credit_o    (credit_o),
    .pass_o      (pass_o),
    .state_o     (state_o),
    .visible_o   (visible_o),
    .vga_o       (vga_o)
);

`default_nettype wire

//--- design/memory_game_top.sv
`timescale 1ns/1ps
`default_nettype none

module memory_game_top #(
    parameter int DEBOUNCE_LEN = 7,
    parameter int H_ACTIVE     = 640,
    parameter int H_FRONT      = 16,
    parameter int H_SYNC       = 96,
    parameter int H_BACK       = 48,
    parameter int V_ACTIVE     = 480,
    parameter int V_FRONT      = 10,
    parameter int V_SYNC       = 2,
    parameter int V_BACK       = 33
) (
    input  logic                         clk,
    input  logic                         rst,
    input  logic                         start_i,
    input  logic                         hint_i,
    input  logic                         pick_valid_i,
    input  memory_game_pkg::pick_t       pick_i,
    output logic                         credit_o,
    output memory_game_pkg::vga_out_t    vga_o,
    output memory_game_pkg::game_state_e state_o,
    output memory_game_pkg::card_mask_t  visible_o,
    output logic                         pass_o
);

    logic                         start_pulse;
    logic                         hsync;
    logic                         vsync;
    memory_game_pkg::card_mask_t  flip_mask;
    memory_game_pkg::screen_pos_t pos;
    memory_game_pkg::tile_coord_t coord;
    memory_game_pkg::rgb_t        rgb;

    start_conditioner #(
        .DEBOUNCE_LEN(DEBOUNCE_LEN)
    ) u_start (
        .clk          (clk),
        .rst          (rst),
        .start_i      (start_i),
        .start_pulse_o(start_pulse)
    );

    game_ctrl u_ctrl (
        .clk           (clk),
        .rst           (rst),
        .start_pulse_i (start_pulse),
        .hint_i        (hint_i),
        .pick_valid_i  (pick_valid_i),
        .pick_i        (pick_i),
        .credit_o      (credit_o),
        .state_o       (state_o),
        .flip_mask_o   (flip_mask),
        .visible_mask_o(visible_o),
        .pass_o        (pass_o)
    );

    vga_timing #(
        .H_ACTIVE(H_ACTIVE), .H_FRONT(H_FRONT), .H_SYNC(H_SYNC), .H_BACK(H_BACK),
        .V_ACTIVE(V_ACTIVE), .V_FRONT(V_FRONT), .V_SYNC(V_SYNC), .V_BACK(V_BACK)
    ) u_timing (
        .clk    (clk),
        .rst    (rst),
        .pos_o  (pos),
        .hsync_o(hsync),
        .vsync_o(vsync)
    );

    tile_addr_gen #(
        .H_ACTIVE(H_ACTIVE),
        .V_ACTIVE(V_ACTIVE)
    ) u_addr (
        .pos_i      (pos),
        .flip_mask_i(flip_mask),
        .coord_o    (coord)
    );

    tile_pixel u_pixel (
        .pos_i         (pos),
        .coord_i       (coord),
        .visible_mask_i(visible_o),
        .rgb_o         (rgb)
    );

    assign vga_o = '{hsync: hsync, vsync: vsync, rgb: rgb};

endmodule

`default_nettype wire

//--- design/tile_pixel.sv
`timescale 1ns/1ps
`default_nettype none

module tile_pixel (
    input  memory_game_pkg::screen_pos_t pos_i,
    input  memory_game_pkg::tile_coord_t coord_i,
    input  memory_game_pkg::card_mask_t  visible_mask_i,
    output memory_game_pkg::rgb_t        rgb_o
);

    localparam int PIC_W = $clog2(memory_game_pkg::NUM_PICTURES);

    logic [PIC_W-1:0]      picture;
    logic [7:0]            palette;
    memory_game_pkg::rgb_t image;
    logic                  show_pixel;

    // Two cards per picture, k and k+8
    assign picture = coord_i.card[PIC_W-1:0];
    assign palette = memory_game_pkg::PICTURE_PALETTE[picture];

    assign image.red   = palette[7:4];
    assign image.green = palette[3:0];
    assign image.blue  = coord_i.row;

    assign show_pixel = pos_i.active && visible_mask_i[coord_i.card];

    // Hidden cards and blanking are black
    assign rgb_o = show_pixel ? image : '0;

endmodule

`default_nettype wire

//--- design/tile_addr_gen.sv
`timescale 1ns/1ps
`default_nettype none

module tile_addr_gen #(
    parameter int H_ACTIVE = 640,
    parameter int V_ACTIVE = 480
) (
    input  memory_game_pkg::screen_pos_t pos_i,
    input  memory_game_pkg::card_mask_t  flip_mask_i,
    output memory_game_pkg::tile_coord_t coord_o
);

    localparam int CW     = memory_game_pkg::COORD_W;
    localparam int GRID   = 4;
    localparam int TILE_W = H_ACTIVE / GRID;
    localparam int TILE_H = V_ACTIVE / GRID;

    logic [CW-1:0]                 col;
    logic [CW-1:0]                 row;
    logic [CW-1:0]                 tile_row;
    logic [CW-1:0]                 img_row;
    memory_game_pkg::card_idx_t    card;

    assign col = pos_i.h / CW'(TILE_W);
    assign row = pos_i.v / CW'(TILE_H);

    // Row major over the 4x4 grid
    assign card = {row[1:0], col[1:0]};

    assign tile_row = pos_i.v % CW'(TILE_H);

    // Flipped cards read their rows bottom up
    assign img_row = flip_mask_i[card] ? CW'(TILE_H - 1) - tile_row : tile_row;

    assign coord_o.card = card;
    assign coord_o.row  = img_row[3:0];

endmodule

`default_nettype wire

//--- design/vga_timing.sv
`timescale 1ns/1ps
`default_nettype none

module vga_timing #(
    parameter int H_ACTIVE = 640,
    parameter int H_FRONT  = 16,
    parameter int H_SYNC   = 96,
    parameter int H_BACK   = 48,
    parameter int V_ACTIVE = 480,
    parameter int V_FRONT  = 10,
    parameter int V_SYNC   = 2,
    parameter int V_BACK   = 33
) (
    input  logic                         clk,
    input  logic                         rst,
    output memory_game_pkg::screen_pos_t pos_o,
    output logic                         hsync_o,
    output logic                         vsync_o
);

    localparam int CW       = memory_game_pkg::COORD_W;
    localparam int H_TOTAL  = H_ACTIVE + H_FRONT + H_SYNC + H_BACK;
    localparam int V_TOTAL  = V_ACTIVE + V_FRONT + V_SYNC + V_BACK;
    localparam int HS_START = H_ACTIVE + H_FRONT;
    localparam int VS_START = V_ACTIVE + V_FRONT;

    logic [CW-1:0] pix_q;
    logic [CW-1:0] pix_d;
    logic [CW-1:0] line_q;
    logic [CW-1:0] line_d;
    logic          active;

    always_comb begin
        pix_d  = pix_q + 1'b1;
        line_d = line_q;
        if (pix_q == CW'(H_TOTAL - 1)) begin
            pix_d  = '0;
            line_d = (line_q == CW'(V_TOTAL - 1)) ? '0 : line_q + 1'b1;
        end
    end

    // Syncs come from the next count so they line up with the counters
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            pix_q   <= '0;
            line_q  <= '0;
            hsync_o <= 1'b1;
            vsync_o <= 1'b1;
        end else begin
            pix_q   <= pix_d;
            line_q  <= line_d;
            hsync_o <= !(pix_d >= CW'(HS_START) && pix_d < CW'(HS_START + H_SYNC));
            vsync_o <= !(line_d >= CW'(VS_START) && line_d < CW'(VS_START + V_SYNC));
        end
    end

    assign active = pix_q < CW'(H_ACTIVE) && line_q < CW'(V_ACTIVE);

    assign pos_o.h      = active ? pix_q : '0;
    assign pos_o.v      = active ? line_q : '0;
    assign pos_o.active = active;

endmodule

`default_nettype wire

//--- design/game_ctrl.sv
`timescale 1ns/1ps
`default_nettype none

module game_ctrl (
    input  logic                        clk,
    input  logic                        rst,
    input  logic                        start_pulse_i,
    input  logic                        hint_i,
    input  logic                        pick_valid_i,
    input  memory_game_pkg::pick_t      pick_i,
    output logic                        credit_o,
    output memory_game_pkg::game_state_e state_o,
    output memory_game_pkg::card_mask_t flip_mask_o,
    output memory_game_pkg::card_mask_t visible_mask_o,
    output logic                        pass_o
);

    localparam int PIC_W = $clog2(memory_game_pkg::NUM_PICTURES);
    localparam int CNT_W = $clog2(memory_game_pkg::WIN_MATCHES + 1);

    memory_game_pkg::game_state_e state_q;
    memory_game_pkg::game_state_e state_d;
    memory_game_pkg::card_mask_t  shown_q;
    memory_game_pkg::card_mask_t  good_q;
    memory_game_pkg::card_mask_t  flip_q;
    logic                         armed_q;
    logic [CNT_W-1:0]             match_cnt_q;
    logic                         boot_done_q;
    logic                         apply_evt;
    logic                         pair_distinct;
    logic                         pair_match;

    always_comb begin
        state_d = state_q;
        case (state_q)
            memory_game_pkg::INIT: begin
                if (start_pulse_i) state_d = memory_game_pkg::SHOW;
            end
            memory_game_pkg::SHOW: begin
                if (start_pulse_i) state_d = memory_game_pkg::GAME;
            end
            memory_game_pkg::GAME: begin
                if (match_cnt_q == CNT_W'(memory_game_pkg::WIN_MATCHES)) begin
                    state_d = memory_game_pkg::FINISH;
                end
            end
            memory_game_pkg::FINISH: begin
                if (start_pulse_i) state_d = memory_game_pkg::INIT;
            end
            default: state_d = memory_game_pkg::INIT;
        endcase
    end

    // Events only act in GAME with the hint released
    assign apply_evt = pick_valid_i && state_q == memory_game_pkg::GAME && !hint_i;

    assign pair_distinct = pick_i.first != pick_i.second;

    // Same picture, same orientation, and no card already solved
    assign pair_match = pair_distinct
        && pick_i.first[PIC_W-1:0] == pick_i.second[PIC_W-1:0]
        && flip_q[pick_i.first] == flip_q[pick_i.second]
        && !good_q[pick_i.first] && !good_q[pick_i.second];

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            state_q     <= memory_game_pkg::INIT;
            shown_q     <= '0;
            good_q      <= '0;
            flip_q      <= '0;
            armed_q     <= 1'b0;
            match_cnt_q <= '0;
            boot_done_q <= 1'b0;
            credit_o    <= 1'b0;
        end else begin
            state_q     <= state_d;
            boot_done_q <= 1'b1;
            // One initial credit, then one back per event
            credit_o    <= pick_valid_i | ~boot_done_q;

            case (state_q)
                memory_game_pkg::INIT: begin
                    shown_q     <= '0;
                    good_q      <= '0;
                    flip_q      <= '0;
                    armed_q     <= 1'b1;
                    match_cnt_q <= '0;
                end
                memory_game_pkg::SHOW: begin
                    shown_q     <= start_pulse_i ? '0 : '1;
                    good_q      <= '0;
                    flip_q      <= memory_game_pkg::SHOW_FLIP_MASK;
                    armed_q     <= 1'b1;
                    match_cnt_q <= '0;
                end
                memory_game_pkg::GAME: begin
                    if (apply_evt) begin
                        case (pick_i.op)
                            memory_game_pkg::PICK_PAIR: begin
                                if (armed_q && pair_distinct) begin
                                    shown_q[pick_i.first]  <= 1'b1;
                                    shown_q[pick_i.second] <= 1'b1;
                                    armed_q                <= 1'b0;
                                    if (pair_match) begin
                                        good_q[pick_i.first]  <= 1'b1;
                                        good_q[pick_i.second] <= 1'b1;
                                        match_cnt_q           <= match_cnt_q + 1'b1;
                                    end
                                end
                            end
                            memory_game_pkg::PICK_ROTATE: begin
                                if (armed_q) begin
                                    shown_q[pick_i.first] <= 1'b1;
                                    flip_q[pick_i.first]  <= ~flip_q[pick_i.first];
                                    armed_q               <= 1'b0;
                                end
                            end
                            memory_game_pkg::PICK_CLEAR: begin
                                if (!armed_q) begin
                                    shown_q <= '0;
                                    armed_q <= 1'b1;
                                end
                            end
                            default: ;
                        endcase
                    end
                end
                memory_game_pkg::FINISH: begin
                    shown_q <= '1;
                    armed_q <= 1'b1;
                end
                default: ;
            endcase
        end
    end

    assign state_o     = state_q;
    assign flip_mask_o = flip_q;
    assign pass_o      = state_q == memory_game_pkg::FINISH;

    // Hint reveals everything while held
    assign visible_mask_o = (state_q == memory_game_pkg::GAME && hint_i)
                          ? '1 : (shown_q | good_q);

endmodule

`default_nettype wire

//--- design/start_conditioner.sv
`timescale 1ns/1ps
`default_nettype none

module start_conditioner #(
    parameter int DEBOUNCE_LEN = 7
) (
    input  logic clk,
    input  logic rst,
    input  logic start_i,
    output logic start_pulse_o
);

    logic [DEBOUNCE_LEN-1:0] samples_q;
    logic                    pressed;
    logic                    pressed_q;

    // Newest sample enters at bit 0
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            samples_q <= '0;
        end else begin
            samples_q <= {samples_q[DEBOUNCE_LEN-2:0], start_i};
        end
    end

    assign pressed = &samples_q;

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            pressed_q <= 1'b0;
        end else begin
            pressed_q <= pressed;
        end
    end

    // Rising edge of the debounced level
    assign start_pulse_o = pressed & ~pressed_q;

endmodule

`default_nettype wire

//--- design/memory_game_pkg.sv
`default_nettype none

package memory_game_pkg;

    localparam int NUM_CARDS    = 16;
    localparam int NUM_PICTURES = 8;
    localparam int WIN_MATCHES  = 8;
    localparam int COORD_W      = 10;

    // Cards 0, 1, 13 and 14 start upside down
    localparam logic [NUM_CARDS-1:0] SHOW_FLIP_MASK = 16'h6003;

    // Red in the high nibble, green in the low nibble
    localparam logic [7:0] PICTURE_PALETTE [NUM_PICTURES] = '{
        8'hF0, 8'h0F, 8'hFF, 8'h84,
        8'h48, 8'hC3, 8'h3C, 8'h99
    };

    typedef enum logic [1:0] {
        INIT,
        SHOW,
        GAME,
        FINISH
    } game_state_e;

    typedef enum logic [1:0] {
        PICK_PAIR,
        PICK_ROTATE,
        PICK_CLEAR
    } pick_op_e;

    typedef logic [3:0] card_idx_t;
    typedef logic [NUM_CARDS-1:0] card_mask_t;

    // second is only looked at for PICK_PAIR
    typedef struct packed {
        pick_op_e  op;
        card_idx_t first;
        card_idx_t second;
    } pick_t;

    typedef struct packed {
        logic [3:0] red;
        logic [3:0] green;
        logic [3:0] blue;
    } rgb_t;

    typedef struct packed {
        logic hsync;
        logic vsync;
        rgb_t rgb;
    } vga_out_t;

    typedef struct packed {
        logic [COORD_W-1:0] h;
        logic [COORD_W-1:0] v;
        logic               active;
    } screen_pos_t;

    typedef struct packed {
        card_idx_t  card;
        logic [3:0] row;
    } tile_coord_t;

endpackage

`default_nettype wire
